//--- source/decoder_settings.svh
`ifndef DECODER_SETTINGS_SVH
`define DECODER_SETTINGS_SVH

// datapath widths
`define WORD_WIDTH      32
`define PC_WIDTH        32
`define GPR_ADDR_WIDTH  5

// instruction field slices, fixed by the ISA
`define FIELD_OPCODE    6:0
`define FIELD_RD        11:7
`define FIELD_FUNCT3    14:12
`define FIELD_RS1       19:15
`define FIELD_RS2       24:20
`define FIELD_FUNCT7    31:25
// sign bit of every immediate
`define INSN_MSB        31

// major opcodes
`define OPC_OP_IMM      7'b0010011
`define OPC_OP          7'b0110011
`define OPC_LUI         7'b0110111
`define OPC_AUIPC       7'b0010111
`define OPC_JAL         7'b1101111
`define OPC_JALR        7'b1100111
`define OPC_BRANCH      7'b1100011
`define OPC_LOAD        7'b0000011
`define OPC_STORE       7'b0100011
`define OPC_SYSTEM      7'b1110011

// whole-word system instructions
`define EBREAK_INSN     32'h0010_0073
`define ECALL_INSN      32'h0000_0073
`define MRET_INSN       32'h3020_0073

// funct7 groups of OP, also the upper imm of shift-right
`define FUNCT7_BASE     7'b0000000
`define FUNCT7_ALT      7'b0100000
`define FUNCT7_MULDIV   7'b0000001

`endif

//--- source/decoder_pkg.sv
`include "decoder_settings.svh"

package decoder_pkg;

    // plain vectors with a meaning
    typedef logic [`WORD_WIDTH-1:0]     word_t;
    typedef logic [`PC_WIDTH-1:0]       pc_t;
    typedef logic [`GPR_ADDR_WIDTH-1:0] gpr_addr_t;

    // opcode class, NONE while fetch is not valid
    typedef enum logic [3:0] {
        CLS_NONE, CLS_OP_IMM, CLS_OP, CLS_LUI, CLS_AUIPC, CLS_JAL,
        CLS_JALR, CLS_BRANCH, CLS_LOAD, CLS_STORE, CLS_SYSTEM, CLS_UNKNOWN
    } insn_class_e;

    // alu operation for the issue queue
    typedef enum logic [4:0] {
        ALU_NOP,
        // immediate forms
        ALU_ADDI, ALU_SLTI, ALU_SLTIU, ALU_XORI, ALU_ORI, ALU_ANDI,
        ALU_SLLI, ALU_SRLI, ALU_SRAI,
        // upper immediates
        ALU_LUI, ALU_AUIPC,
        // register forms
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND,
        // M extension
        ALU_MUL, ALU_MULH, ALU_MULHSU, ALU_MULHU,
        ALU_DIV, ALU_DIVU, ALU_REM, ALU_REMU
    } alu_op_e;

    typedef enum logic [3:0] {
        MEM_NOP, MEM_LW, MEM_LH, MEM_LHU, MEM_LB, MEM_LBU, MEM_SW, MEM_SH, MEM_SB
    } mem_op_e;

    typedef enum logic [3:0] {
        BR_NOP, BR_JAL, BR_JALR, BR_BEQ, BR_BNE, BR_BLT, BR_BLTU, BR_BGE, BR_BGEU
    } br_op_e;

    typedef enum logic [1:0] {
        EXP_NO_EXP, EXP_UNDEF_INSN
    } exp_code_e;

    // fields for the reorder buffer
    typedef struct packed {
        gpr_addr_t rs1_addr;
        gpr_addr_t rs2_addr;
        gpr_addr_t dst_addr;
        logic      dst_wen;
        word_t     imm;
    } operand_s;

    // early jump resolution, rs1_addr goes back to the rename table
    typedef struct packed {
        logic      taken;
        pc_t       addr;
        gpr_addr_t rs1_addr;
        logic      stall;
    } jump_s;

    // strobes for cpu control
    typedef struct packed {
        logic ebreak;
        logic ecall;
        logic mret;
    } sys_evt_s;

endpackage

//--- source/insn_classify.sv
`timescale 1ns/100ps
`include "decoder_settings.svh"

module insn_classify import decoder_pkg::*; (
    input  logic        if_en,
    input  word_t       if_insn,
    output insn_class_e insn_class,
    output mem_op_e     mem_op
);

    logic [2:0] funct3;

    assign funct3 = if_insn[`FIELD_FUNCT3];

    // one class per opcode, NONE gates everything downstream
    always_comb begin
        if (!if_en) begin
            insn_class = CLS_NONE;
        end else begin
            case (if_insn[`FIELD_OPCODE])
                `OPC_OP_IMM: insn_class = CLS_OP_IMM;
                `OPC_OP:     insn_class = CLS_OP;
                `OPC_LUI:    insn_class = CLS_LUI;
                `OPC_AUIPC:  insn_class = CLS_AUIPC;
                `OPC_JAL:    insn_class = CLS_JAL;
                `OPC_JALR:   insn_class = CLS_JALR;
                `OPC_BRANCH: insn_class = CLS_BRANCH;
                `OPC_LOAD:   insn_class = CLS_LOAD;
                `OPC_STORE:  insn_class = CLS_STORE;
                `OPC_SYSTEM: insn_class = CLS_SYSTEM;
                default:     insn_class = CLS_UNKNOWN;
            endcase
        end
    end

    // width and signedness of memory accesses
    always_comb begin
        mem_op = MEM_NOP;
        if (insn_class == CLS_LOAD) begin
            case (funct3)
                3'b000:  mem_op = MEM_LB;
                3'b001:  mem_op = MEM_LH;
                3'b010:  mem_op = MEM_LW;
                3'b100:  mem_op = MEM_LBU;
                3'b101:  mem_op = MEM_LHU;
                default: mem_op = MEM_NOP;
            endcase
        end else if (insn_class == CLS_STORE) begin
            // stores have no unsigned forms
            case (funct3)
                3'b000:  mem_op = MEM_SB;
                3'b001:  mem_op = MEM_SH;
                3'b010:  mem_op = MEM_SW;
                default: mem_op = MEM_NOP;
            endcase
        end
    end

endmodule

//--- source/operand_extract.sv
`timescale 1ns/100ps
`include "decoder_settings.svh"

module operand_extract import decoder_pkg::*; (
    input  insn_class_e insn_class,
    input  word_t       if_insn,
    output operand_s    operand
);

    word_t imm_i;
    word_t imm_u;
    word_t imm_j;
    word_t imm_b;
    word_t imm_s;
    logic  sys_csr;

    // immediates of every format, all sign-extended from bit 31
    assign imm_i = {{20{if_insn[`INSN_MSB]}}, if_insn[31:20]};
    assign imm_u = {if_insn[31:12], 12'b0};
    // j-type scrambles imm[20|10:1|11|19:12]
    assign imm_j = {{12{if_insn[`INSN_MSB]}}, if_insn[19:12], if_insn[20],
                    if_insn[30:21], 1'b0};
    // b-type scrambles imm[12|10:5] and imm[4:1|11]
    assign imm_b = {{20{if_insn[`INSN_MSB]}}, if_insn[7], if_insn[30:25],
                    if_insn[11:8], 1'b0};
    assign imm_s = {{20{if_insn[`INSN_MSB]}}, if_insn[31:25], if_insn[11:7]};

    // csr forms have nonzero funct3, ecall/ebreak/mret do not
    assign sys_csr = (if_insn[`FIELD_FUNCT3] != 3'b000);

    always_comb begin
        operand = '0;
        case (insn_class)
            CLS_OP_IMM, CLS_JALR, CLS_LOAD: begin
                operand.rs1_addr = if_insn[`FIELD_RS1];
                operand.dst_addr = if_insn[`FIELD_RD];
                operand.dst_wen  = 1'b1;
                operand.imm      = imm_i;
            end
            CLS_LUI, CLS_AUIPC: begin
                operand.dst_addr = if_insn[`FIELD_RD];
                operand.dst_wen  = 1'b1;
                operand.imm      = imm_u;
            end
            CLS_OP: begin
                // register-register, no immediate
                operand.rs1_addr = if_insn[`FIELD_RS1];
                operand.rs2_addr = if_insn[`FIELD_RS2];
                operand.dst_addr = if_insn[`FIELD_RD];
                operand.dst_wen  = 1'b1;
            end
            CLS_JAL: begin
                operand.dst_addr = if_insn[`FIELD_RD];
                operand.dst_wen  = 1'b1;
                operand.imm      = imm_j;
            end
            CLS_BRANCH: begin
                operand.rs1_addr = if_insn[`FIELD_RS1];
                operand.rs2_addr = if_insn[`FIELD_RS2];
                operand.imm      = imm_b;
            end
            CLS_STORE: begin
                operand.rs1_addr = if_insn[`FIELD_RS1];
                operand.rs2_addr = if_insn[`FIELD_RS2];
                operand.imm      = imm_s;
            end
            CLS_SYSTEM: begin
                // imm carries the csr address
                if (sys_csr) begin
                    operand.rs1_addr = if_insn[`FIELD_RS1];
                    operand.dst_addr = if_insn[`FIELD_RD];
                    operand.dst_wen  = 1'b1;
                    operand.imm      = imm_i;
                end
            end
            // NONE and UNKNOWN stay zero
            default: operand = '0;
        endcase
    end

endmodule

//--- source/alu_op_decode.sv
`timescale 1ns/100ps
`include "decoder_settings.svh"

module alu_op_decode import decoder_pkg::*; (
    input  insn_class_e insn_class,
    input  word_t       if_insn,
    output alu_op_e     alu_op
);

    logic [2:0] funct3;
    logic [6:0] funct7;

    assign funct3 = if_insn[`FIELD_FUNCT3];
    // for OP_IMM shifts this is imm[11:5]
    assign funct7 = if_insn[`FIELD_FUNCT7];

    always_comb begin
        alu_op = ALU_NOP;
        case (insn_class)
            CLS_OP_IMM: begin
                case (funct3)
                    3'b000: alu_op = ALU_ADDI;
                    3'b001: alu_op = ALU_SLLI;
                    3'b010: alu_op = ALU_SLTI;
                    3'b011: alu_op = ALU_SLTIU;
                    3'b100: alu_op = ALU_XORI;
                    3'b101: begin
                        // logical vs arithmetic by imm[11:5]
                        if (funct7 == `FUNCT7_BASE) begin
                            alu_op = ALU_SRLI;
                        end else if (funct7 == `FUNCT7_ALT) begin
                            alu_op = ALU_SRAI;
                        end
                    end
                    3'b110: alu_op = ALU_ORI;
                    default: alu_op = ALU_ANDI;
                endcase
            end
            CLS_OP: begin
                if (funct7 == `FUNCT7_BASE) begin
                    case (funct3)
                        3'b000: alu_op = ALU_ADD;
                        3'b001: alu_op = ALU_SLL;
                        3'b010: alu_op = ALU_SLT;
                        3'b011: alu_op = ALU_SLTU;
                        3'b100: alu_op = ALU_XOR;
                        3'b101: alu_op = ALU_SRL;
                        3'b110: alu_op = ALU_OR;
                        default: alu_op = ALU_AND;
                    endcase
                end else if (funct7 == `FUNCT7_ALT) begin
                    // only sub and sra live here
                    case (funct3)
                        3'b000:  alu_op = ALU_SUB;
                        3'b101:  alu_op = ALU_SRA;
                        default: alu_op = ALU_NOP;
                    endcase
                end else if (funct7 == `FUNCT7_MULDIV) begin
                    case (funct3)
                        3'b000: alu_op = ALU_MUL;
                        3'b001: alu_op = ALU_MULH;
                        3'b010: alu_op = ALU_MULHSU;
                        3'b011: alu_op = ALU_MULHU;
                        3'b100: alu_op = ALU_DIV;
                        3'b101: alu_op = ALU_DIVU;
                        3'b110: alu_op = ALU_REM;
                        default: alu_op = ALU_REMU;
                    endcase
                end
            end
            CLS_LUI:   alu_op = ALU_LUI;
            CLS_AUIPC: alu_op = ALU_AUIPC;
            // branches, memory and system use other units
            default:   alu_op = ALU_NOP;
        endcase
    end

endmodule

//--- source/ctrl_transfer_decode.sv
`timescale 1ns/100ps
`include "decoder_settings.svh"

module ctrl_transfer_decode import decoder_pkg::*; (
    input  insn_class_e insn_class,
    input  word_t       if_insn,
    input  pc_t         if_pc,
    input  gpr_addr_t   rs1_addr,
    input  word_t       imm,
    input  logic        jp_rs1_rat_valid,
    input  word_t       jp_rs1_data,
    output br_op_e      br_op,
    output jump_s       jump
);

    logic rs1_zero;

    assign rs1_zero = (rs1_addr == '0);

    // compare kind for the branch unit
    always_comb begin
        case (insn_class)
            CLS_JAL:  br_op = BR_JAL;
            CLS_JALR: br_op = BR_JALR;
            CLS_BRANCH: begin
                case (if_insn[`FIELD_FUNCT3])
                    3'b000:  br_op = BR_BEQ;
                    3'b001:  br_op = BR_BNE;
                    3'b100:  br_op = BR_BLT;
                    3'b101:  br_op = BR_BGE;
                    3'b110:  br_op = BR_BLTU;
                    3'b111:  br_op = BR_BGEU;
                    default: br_op = BR_NOP;
                endcase
            end
            default:  br_op = BR_NOP;
        endcase
    end

    // jal and jalr resolved here, no wait on the branch unit
    always_comb begin
        jump = '0;
        if (insn_class == CLS_JAL) begin
            jump.taken = 1'b1;
            jump.addr  = if_pc + imm;
        end else if (insn_class == CLS_JALR) begin
            // rename table looks up this register
            jump.rs1_addr = rs1_addr;
            if (rs1_zero) begin
                // x0 base, target is the offset alone
                jump.taken = 1'b1;
                jump.addr  = imm;
            end else if (!jp_rs1_rat_valid) begin
                jump.taken = 1'b1;
                jump.addr  = jp_rs1_data + imm;
            end else begin
                // rs1 still in flight, hold fetch
                jump.stall = 1'b1;
            end
        end
    end

endmodule

//--- source/exception_check.sv
`timescale 1ns/100ps
`include "decoder_settings.svh"

module exception_check import decoder_pkg::*; (
    input  insn_class_e insn_class,
    input  word_t       if_insn,
    input  alu_op_e     alu_op,
    output sys_evt_s    sys_evt,
    output exp_code_e   exp_code
);

    logic valid;
    logic arith;

    // NONE means fetch not valid
    assign valid = (insn_class != CLS_NONE);
    assign arith = (insn_class == CLS_OP_IMM) || (insn_class == CLS_OP);

    // whole-word compares, any other system form is a csr access
    assign sys_evt.ebreak = valid && (if_insn == `EBREAK_INSN);
    assign sys_evt.ecall  = valid && (if_insn == `ECALL_INSN);
    assign sys_evt.mret   = valid && (if_insn == `MRET_INSN);

    // arithmetic that found no alu op has a bad funct field
    always_comb begin
        if (insn_class == CLS_UNKNOWN) begin
            exp_code = EXP_UNDEF_INSN;
        end else if (arith && (alu_op == ALU_NOP)) begin
            exp_code = EXP_UNDEF_INSN;
        end else begin
            exp_code = EXP_NO_EXP;
        end
    end

endmodule

//--- source/decoder_top.sv
`timescale 1ns/100ps

module decoder_top import decoder_pkg::*; (
    // fetch side
    input  logic      if_en,
    input  pc_t       if_pc,
    input  word_t     if_insn,
    // jalr base from rename table and register file
    input  logic      jp_rs1_rat_valid,
    input  word_t     jp_rs1_data,
    // to reorder buffer
    output operand_s  operand,
    // to issue queue
    output alu_op_e   alu_op,
    output mem_op_e   mem_op,
    output br_op_e    br_op,
    // to fetch and rename table
    output jump_s     jump,
    // to cpu control
    output sys_evt_s  sys_evt,
    output exp_code_e exp_code
);

    insn_class_e insn_class;

    insn_classify u_classify (
        .if_en      (if_en),
        .if_insn    (if_insn),
        .insn_class (insn_class),
        .mem_op     (mem_op)
    );

    operand_extract u_operand (
        .insn_class (insn_class),
        .if_insn    (if_insn),
        .operand    (operand)
    );

    alu_op_decode u_alu_op (
        .insn_class (insn_class),
        .if_insn    (if_insn),
        .alu_op     (alu_op)
    );

    // jalr base and offset come from the operand fields
    ctrl_transfer_decode u_ctrl_transfer (
        .insn_class       (insn_class),
        .if_insn          (if_insn),
        .if_pc            (if_pc),
        .rs1_addr         (operand.rs1_addr),
        .imm              (operand.imm),
        .jp_rs1_rat_valid (jp_rs1_rat_valid),
        .jp_rs1_data      (jp_rs1_data),
        .br_op            (br_op),
        .jump             (jump)
    );

    exception_check u_exception (
        .insn_class (insn_class),
        .if_insn    (if_insn),
        .alu_op     (alu_op),
        .sys_evt    (sys_evt),
        .exp_code   (exp_code)
    );

endmodule

//--- verif/tb_decoder.sv
`timescale 1ns/100ps
`include "decoder_settings.svh"

module tb_decoder import decoder_pkg::*; ();

    // reset plus about 1250 vectors, with margin
    localparam int CYCLE_LIMIT = 2000;

    localparam logic [6:0] KNOWN_OPC [10] = '{
        `OPC_OP_IMM, `OPC_OP, `OPC_LUI, `OPC_AUIPC, `OPC_JAL,
        `OPC_JALR, `OPC_BRANCH, `OPC_LOAD, `OPC_STORE, `OPC_SYSTEM
    };
    // funct3 indexed lookup tables
    localparam alu_op_e IMM_OPS [8] = '{
        ALU_ADDI, ALU_SLLI, ALU_SLTI, ALU_SLTIU, ALU_XORI, ALU_SRLI, ALU_ORI, ALU_ANDI
    };
    localparam alu_op_e REG_OPS [8] = '{
        ALU_ADD, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR, ALU_SRL, ALU_OR, ALU_AND
    };
    localparam alu_op_e MULDIV_OPS [8] = '{
        ALU_MUL, ALU_MULH, ALU_MULHSU, ALU_MULHU, ALU_DIV, ALU_DIVU, ALU_REM, ALU_REMU
    };
    localparam mem_op_e LOAD_OPS [8] = '{
        MEM_LB, MEM_LH, MEM_LW, MEM_NOP, MEM_LBU, MEM_LHU, MEM_NOP, MEM_NOP
    };
    localparam mem_op_e STORE_OPS [8] = '{
        MEM_SB, MEM_SH, MEM_SW, MEM_NOP, MEM_NOP, MEM_NOP, MEM_NOP, MEM_NOP
    };
    localparam br_op_e BRANCH_OPS [8] = '{
        BR_BEQ, BR_BNE, BR_NOP, BR_NOP, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU
    };

    logic      clk;
    logic      rst_n;
    logic      if_en;
    pc_t       if_pc;
    word_t     if_insn;
    logic      jp_rs1_rat_valid;
    word_t     jp_rs1_data;

    operand_s  operand;
    alu_op_e   alu_op;
    mem_op_e   mem_op;
    br_op_e    br_op;
    jump_s     jump;
    sys_evt_s  sys_evt;
    exp_code_e exp_code;

    // reference values
    operand_s  exp_operand;
    alu_op_e   exp_alu_op;
    mem_op_e   exp_mem_op;
    br_op_e    exp_br_op;
    jump_s     exp_jump;
    sys_evt_s  exp_sys_evt;
    exp_code_e exp_exp_code;

    integer seed;
    int     errors;
    int     vectors;
    int     cycles;

    decoder_top u_dut (
        .if_en            (if_en),
        .if_pc            (if_pc),
        .if_insn          (if_insn),
        .jp_rs1_rat_valid (jp_rs1_rat_valid),
        .jp_rs1_data      (jp_rs1_data),
        .operand          (operand),
        .alu_op           (alu_op),
        .mem_op           (mem_op),
        .br_op            (br_op),
        .jump             (jump),
        .sys_evt          (sys_evt),
        .exp_code         (exp_code)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic is_known(logic [6:0] opc);
        foreach (KNOWN_OPC[i]) begin
            if (KNOWN_OPC[i] == opc) return 1'b1;
        end
        return 1'b0;
    endfunction

    // immediate by format, straight from the ISA bit maps
    function automatic word_t imm_of(word_t insn);
        case (insn[6:0])
            `OPC_OP_IMM, `OPC_JALR, `OPC_LOAD, `OPC_SYSTEM:
                return {{21{insn[31]}}, insn[30:20]};
            `OPC_LUI, `OPC_AUIPC:
                return {insn[31:12], 12'h000};
            `OPC_JAL:
                return {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};
            `OPC_BRANCH:
                return {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
            `OPC_STORE:
                return {{20{insn[31]}}, insn[31:25], insn[11:7]};
            default:
                return '0;
        endcase
    endfunction

    function automatic operand_s ref_operand(logic en, word_t insn);
        operand_s o;
        logic     rd_w;
        logic     rs1_r;
        logic     rs2_r;
        o = '0;
        {rd_w, rs1_r, rs2_r} = 3'b000;
        if (en) begin
            case (insn[6:0])
                `OPC_OP_IMM, `OPC_JALR, `OPC_LOAD: {rd_w, rs1_r, rs2_r} = 3'b110;
                `OPC_LUI, `OPC_AUIPC, `OPC_JAL:    {rd_w, rs1_r, rs2_r} = 3'b100;
                `OPC_OP:                           {rd_w, rs1_r, rs2_r} = 3'b111;
                `OPC_BRANCH, `OPC_STORE:           {rd_w, rs1_r, rs2_r} = 3'b011;
                // only csr forms touch registers
                `OPC_SYSTEM: {rd_w, rs1_r, rs2_r} = (insn[14:12] != 3'b000) ? 3'b110 : 3'b000;
                default:                           {rd_w, rs1_r, rs2_r} = 3'b000;
            endcase
        end
        if (rs1_r) o.rs1_addr = insn[19:15];
        if (rs2_r) o.rs2_addr = insn[24:20];
        if (rd_w) o.dst_addr = insn[11:7];
        o.dst_wen = rd_w;
        // OP has no immediate, imm_of already gives zero there
        if (rd_w || rs2_r) o.imm = imm_of(insn);
        return o;
    endfunction

    function automatic alu_op_e ref_alu_op(logic en, word_t insn);
        logic [2:0] f3;
        logic [6:0] f7;
        f3 = insn[14:12];
        f7 = insn[31:25];
        if (!en) return ALU_NOP;
        case (insn[6:0])
            `OPC_OP_IMM: begin
                if (f3 != 3'b101) return IMM_OPS[f3];
                if (f7 == `FUNCT7_BASE) return ALU_SRLI;
                if (f7 == `FUNCT7_ALT) return ALU_SRAI;
                return ALU_NOP;
            end
            `OPC_OP: begin
                if (f7 == `FUNCT7_BASE) return REG_OPS[f3];
                if (f7 == `FUNCT7_MULDIV) return MULDIV_OPS[f3];
                if (f7 == `FUNCT7_ALT && f3 == 3'b000) return ALU_SUB;
                if (f7 == `FUNCT7_ALT && f3 == 3'b101) return ALU_SRA;
                return ALU_NOP;
            end
            `OPC_LUI:   return ALU_LUI;
            `OPC_AUIPC: return ALU_AUIPC;
            default:    return ALU_NOP;
        endcase
    endfunction

    function automatic jump_s ref_jump(logic en, word_t insn, pc_t pc, logic pend, word_t data);
        jump_s j;
        j = '0;
        if (en && insn[6:0] == `OPC_JAL) begin
            j.taken = 1'b1;
            j.addr  = pc + imm_of(insn);
        end else if (en && insn[6:0] == `OPC_JALR) begin
            j.rs1_addr = insn[19:15];
            // x0 base needs no rename lookup
            if (insn[19:15] == 5'd0) begin
                j.taken = 1'b1;
                j.addr  = imm_of(insn);
            end else if (!pend) begin
                j.taken = 1'b1;
                j.addr  = data + imm_of(insn);
            end else begin
                j.stall = 1'b1;
            end
        end
        return j;
    endfunction

    always_comb begin
        exp_operand = ref_operand(if_en, if_insn);
        exp_alu_op  = ref_alu_op(if_en, if_insn);
        exp_mem_op  = MEM_NOP;
        exp_br_op   = BR_NOP;
        if (if_en && if_insn[6:0] == `OPC_LOAD) exp_mem_op = LOAD_OPS[if_insn[14:12]];
        if (if_en && if_insn[6:0] == `OPC_STORE) exp_mem_op = STORE_OPS[if_insn[14:12]];
        if (if_en && if_insn[6:0] == `OPC_BRANCH) exp_br_op = BRANCH_OPS[if_insn[14:12]];
        if (if_en && if_insn[6:0] == `OPC_JAL) exp_br_op = BR_JAL;
        if (if_en && if_insn[6:0] == `OPC_JALR) exp_br_op = BR_JALR;
        exp_jump = ref_jump(if_en, if_insn, if_pc, jp_rs1_rat_valid, jp_rs1_data);
        exp_sys_evt.ebreak = if_en && (if_insn == `EBREAK_INSN);
        exp_sys_evt.ecall  = if_en && (if_insn == `ECALL_INSN);
        exp_sys_evt.mret   = if_en && (if_insn == `MRET_INSN);
        // bad opcode, or arithmetic with a bad funct field
        exp_exp_code = EXP_NO_EXP;
        if (if_en && !is_known(if_insn[6:0])) exp_exp_code = EXP_UNDEF_INSN;
        if (if_en && (if_insn[6:0] == `OPC_OP_IMM || if_insn[6:0] == `OPC_OP)
            && exp_alu_op == ALU_NOP) exp_exp_code = EXP_UNDEF_INSN;
    end

    task automatic report_mismatch(string name, logic [47:0] expected, logic [47:0] actual);
        errors++;
        $display("MISMATCH %0t %s expected=%h actual=%h", $time, name, expected, actual);
    endtask

    // outputs settle within the cycle, sampled at the next edge
    chk_operand: assert property (@(posedge clk) disable iff (!rst_n) operand == exp_operand)
        else report_mismatch("operand", $sampled(exp_operand), $sampled(operand));
    chk_alu_op: assert property (@(posedge clk) disable iff (!rst_n) alu_op == exp_alu_op)
        else report_mismatch("alu_op", $sampled(exp_alu_op), $sampled(alu_op));
    chk_mem_op: assert property (@(posedge clk) disable iff (!rst_n) mem_op == exp_mem_op)
        else report_mismatch("mem_op", $sampled(exp_mem_op), $sampled(mem_op));
    chk_br_op: assert property (@(posedge clk) disable iff (!rst_n) br_op == exp_br_op)
        else report_mismatch("br_op", $sampled(exp_br_op), $sampled(br_op));
    chk_jump: assert property (@(posedge clk) disable iff (!rst_n) jump == exp_jump)
        else report_mismatch("jump", $sampled(exp_jump), $sampled(jump));
    chk_sys_evt: assert property (@(posedge clk) disable iff (!rst_n) sys_evt == exp_sys_evt)
        else report_mismatch("sys_evt", $sampled(exp_sys_evt), $sampled(sys_evt));
    chk_exp_code: assert property (@(posedge clk) disable iff (!rst_n) exp_code == exp_exp_code)
        else report_mismatch("exp_code", $sampled(exp_exp_code), $sampled(exp_code));

    function automatic word_t rnd_word();
        return $random(seed);
    endfunction

    function automatic word_t with_opcode(word_t w, logic [6:0] opc);
        return {w[31:7], opc};
    endfunction

    // one vector per edge, pc, pending level and rs1 data random
    task automatic drive(logic en, word_t insn);
        word_t r;
        r = rnd_word();
        @(posedge clk);
        if_en            <= en;
        if_insn          <= insn;
        if_pc            <= rnd_word();
        jp_rs1_rat_valid <= r[0];
        jp_rs1_data      <= rnd_word();
        vectors++;
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: cycle limit of %0d reached before the tests ended", CYCLE_LIMIT);
            $display("Done: errors found");
            $finish;
        end
    end

    initial begin
        word_t      w;
        logic [6:0] f7_pick [4];
        seed             = 32'he0fb;
        errors           = 0;
        vectors          = 0;
        cycles           = 0;
        rst_n            = 1'b0;
        if_en            = 1'b0;
        if_pc            = '0;
        if_insn          = '0;
        jp_rs1_rat_valid = 1'b0;
        jp_rs1_data      = '0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;

        // operand fields over every known opcode
        repeat (200) drive(1'b1, with_opcode(rnd_word(), KNOWN_OPC[rnd_word() % 10]));

        // alu ops, funct7 groups plus a random one
        repeat (3) begin
            w = rnd_word();
            f7_pick = '{`FUNCT7_BASE, `FUNCT7_ALT, `FUNCT7_MULDIV, w[31:25]};
            for (int g = 0; g < 4; g++) begin
                for (int f3 = 0; f3 < 8; f3++) begin
                    w = rnd_word();
                    w[14:12] = 3'(f3);
                    w[31:25] = f7_pick[g];
                    drive(1'b1, with_opcode(w, `OPC_OP_IMM));
                    drive(1'b1, with_opcode(w, `OPC_OP));
                end
            end
        end

        // load, store and branch funct3 sweep
        repeat (8) begin
            for (int f3 = 0; f3 < 8; f3++) begin
                w = rnd_word();
                w[14:12] = 3'(f3);
                drive(1'b1, with_opcode(w, `OPC_LOAD));
                drive(1'b1, with_opcode(w, `OPC_STORE));
                drive(1'b1, with_opcode(w, `OPC_BRANCH));
            end
        end

        // jal and jalr, every fourth with an x0 base
        for (int i = 0; i < 200; i++) begin
            w = with_opcode(rnd_word(), (i % 2 == 1) ? `OPC_JALR : `OPC_JAL);
            if (i % 4 == 1) w[19:15] = 5'd0;
            drive(1'b1, w);
        end

        // system words, csr forms and unknown opcodes
        repeat (50) begin
            drive(1'b1, `EBREAK_INSN);
            drive(1'b1, `ECALL_INSN);
            drive(1'b1, `MRET_INSN);
            w = with_opcode(rnd_word(), `OPC_SYSTEM);
            if (w[14:12] == 3'b000) w[14:12] = 3'b001;
            drive(1'b1, w);
            w = rnd_word();
            while (is_known(w[6:0])) w = rnd_word();
            drive(1'b1, w);
        end

        // fetch not valid
        for (int i = 0; i < 200; i++) begin
            w = with_opcode(rnd_word(), KNOWN_OPC[i % 10]);
            if (i % 20 == 7) w = `EBREAK_INSN;
            drive(1'b0, w);
        end

        // let the last vector be sampled
        @(posedge clk);
        @(posedge clk);
        $display("vectors: %0d, errors: %0d", vectors, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- verilog.f
+incdir+source
source/decoder_pkg.sv
source/insn_classify.sv
source/operand_extract.sv
source/alu_op_decode.sv
source/ctrl_transfer_decode.sv
source/exception_check.sv
source/decoder_top.sv
verif/tb_decoder.sv
